// File: verilog/arith_core_consts.svh
/*
  Sizing constants of the arithmetic core
*/

`ifndef ARITH_CORE_CONSTS_SVH
`define ARITH_CORE_CONSTS_SVH

// Architectural registers
`define NUM_REGS 32
// Sequence-number tag width
`define SEQ_NUM_BITS 8
// Multiplier latency in cycles
`define MUL_STAGES 3

`endif

// File: verilog/rv_isa_pkg.sv
/*
  Instruction-side types for the arithmetic RISC-V subset
  Raw word, register number, field types, uop enum
  Opcode and funct constants for add, addi and mul
*/

package rv_isa_pkg;

  // Raw 32-bit instruction word
  typedef logic [31:0] inst_t;

  // Architectural register number, x0..x31
  typedef logic [4:0] reg_addr_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Decoded operation
  typedef enum logic [1:0] {
    uop_add,
    uop_addi,
    uop_mul
  } rv_uop_t;

  // ----------------------------------------------------------
  // Encodings of the supported subset
  // ----------------------------------------------------------

  // R-type register-register ops (add, mul)
  localparam opcode_t opc_op     = 7'b0110011;
  // I-type register-immediate ops (addi)
  localparam opcode_t opc_op_imm = 7'b0010011;

  localparam funct3_t funct3_add = 3'b000;

  // funct7 tells add from mul (M extension)
  localparam funct7_t funct7_add = 7'b0000000;
  localparam funct7_t funct7_mul = 7'b0000001;

endpackage

// File: verilog/issue_pkg.sv
/*
  Pipeline-side types
  Data word, sequence number, pipe selection
*/

`include "arith_core_consts.svh"

package issue_pkg;

  // Operands, results and pc
  typedef logic [31:0] word_t;

  // Program-order tag carried from fetch to completion
  typedef logic [`SEQ_NUM_BITS-1:0] seq_num_t;

  // Target pipe of an issued instruction
  typedef enum logic {
    pipe_alu,
    pipe_mul
  } pipe_sel_t;

endpackage

// File: verilog/inst_decoder.sv
/*
  Combinational decoder for add, addi and mul
  Produces uop, register numbers, write enable and immediate
*/

`timescale 1ns/1ps

module inst_decoder (
  input  rv_isa_pkg::inst_t     inst,
  output logic                  val,
  output rv_isa_pkg::rv_uop_t   uop,
  output rv_isa_pkg::reg_addr_t raddr0,
  output rv_isa_pkg::reg_addr_t raddr1,
  output rv_isa_pkg::reg_addr_t waddr,
  output logic                  wen,
  output logic                  use_imm,
  output issue_pkg::word_t      imm
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;

  // Field slices
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // I-type immediate, sign bit is inst[31]
  assign imm    = {{20{inst[31]}}, inst[31:20]};

  // rd and rs1 sit in the same place for R and I types
  assign waddr  = inst[11:7];
  assign raddr0 = inst[19:15];

  always_comb begin
    // Unknown opcodes decode as invalid
    val     = 1'b0;
    uop     = rv_isa_pkg::uop_add;
    wen     = 1'b0;
    use_imm = 1'b0;
    raddr1  = inst[24:20];

    if (opcode == rv_isa_pkg::opc_op && funct3 == rv_isa_pkg::funct3_add) begin
      if (funct7 == rv_isa_pkg::funct7_add) begin
        val = 1'b1;
        uop = rv_isa_pkg::uop_add;
        wen = 1'b1;
      end else if (funct7 == rv_isa_pkg::funct7_mul) begin
        val = 1'b1;
        uop = rv_isa_pkg::uop_mul;
        wen = 1'b1;
      end
    end else if (opcode == rv_isa_pkg::opc_op_imm && funct3 == rv_isa_pkg::funct3_add) begin
      val     = 1'b1;
      uop     = rv_isa_pkg::uop_addi;
      wen     = 1'b1;
      use_imm = 1'b1;
      // Imm bits are not rs2, point at x0 so no false stall
      raddr1  = '0;
    end
  end

endmodule

// File: verilog/regfile_pending.sv
/*
  Register file with pending bits
  Two read ports, one write port, one destination check port
*/

`timescale 1ns/1ps

`include "arith_core_consts.svh"

module regfile_pending (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t raddr0,
  input  rv_isa_pkg::reg_addr_t raddr1,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  issue_pkg::word_t      wdata,
  input  logic                  wen,
  input  rv_isa_pkg::reg_addr_t set_addr,
  input  logic                  set_en,
  input  rv_isa_pkg::reg_addr_t chk_addr,
  output issue_pkg::word_t      rdata0,
  output issue_pkg::word_t      rdata1,
  output logic                  pend0,
  output logic                  pend1,
  output logic                  chk_pend
);

  issue_pkg::word_t         regs [`NUM_REGS];
  logic [`NUM_REGS-1:0]     pending;

  // ----------------------------------------------------------
  // Data array
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // ----------------------------------------------------------
  // Pending bits
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      // Completion clears first
      if (wen)
        pending[waddr] <= 1'b0;
      // New issue wins on the same register
      if (set_en && set_addr != '0)
        pending[set_addr] <= 1'b1;
    end
  end

  // x0 never pending
  assign pend0    = (raddr0 != '0) & pending[raddr0];
  assign pend1    = (raddr1 != '0) & pending[raddr1];
  assign chk_pend = (chk_addr != '0) & pending[chk_addr];

endmodule

// File: verilog/decode_issue_unit.sv
/*
  In-order single-issue decode stage
  Fetch register, hazard stall, operand select, pipe routing
*/

`timescale 1ns/1ps

module decode_issue_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  f_val,
  output logic                  f_rdy,
  input  rv_isa_pkg::inst_t     f_inst,
  input  issue_pkg::word_t      f_pc,
  input  issue_pkg::seq_num_t   f_seq_num,
  output logic                  alu_val,
  input  logic                  alu_rdy,
  output logic                  mul_val,
  output rv_isa_pkg::rv_uop_t   iss_uop,
  output issue_pkg::word_t      iss_op1,
  output issue_pkg::word_t      iss_op2,
  output rv_isa_pkg::reg_addr_t iss_waddr,
  output issue_pkg::seq_num_t   iss_seq_num,
  input  logic                  cmt_val,
  input  rv_isa_pkg::reg_addr_t cmt_waddr,
  input  issue_pkg::word_t      cmt_wdata
);

  // ----------------------------------------------------------
  // Fetch register
  // ----------------------------------------------------------

  logic                fd_val;
  rv_isa_pkg::inst_t   fd_inst;
  issue_pkg::word_t    fd_pc;
  issue_pkg::seq_num_t fd_seq_num;
  logic                f_xfer;
  logic                issue;

  assign f_xfer = f_val & f_rdy;

  always_ff @(posedge clk) begin
    if (rst)
      fd_val <= 1'b0;
    else if (f_xfer)
      fd_val <= 1'b1;
    else if (issue)
      fd_val <= 1'b0;
  end

  // Payload, only loaded on a transfer
  always_ff @(posedge clk) begin
    if (f_xfer) begin
      fd_inst    <= f_inst;
      fd_pc      <= f_pc;
      fd_seq_num <= f_seq_num;
    end
  end

  // ----------------------------------------------------------
  // Decoder and register file
  // ----------------------------------------------------------

  logic                  dec_val;
  rv_isa_pkg::rv_uop_t   dec_uop;
  rv_isa_pkg::reg_addr_t dec_raddr0;
  rv_isa_pkg::reg_addr_t dec_raddr1;
  rv_isa_pkg::reg_addr_t dec_waddr;
  logic                  dec_wen;
  logic                  dec_use_imm;
  issue_pkg::word_t      dec_imm;
  issue_pkg::word_t      rdata0;
  issue_pkg::word_t      rdata1;
  logic                  pend0;
  logic                  pend1;
  logic                  dst_pend;

  inst_decoder decoder (
    .inst    (fd_inst),
    .val     (dec_val),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .use_imm (dec_use_imm),
    .imm     (dec_imm)
  );

  // Completions write and clear, issue sets the destination
  regfile_pending regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .waddr    (cmt_waddr),
    .wdata    (cmt_wdata),
    .wen      (cmt_val),
    .set_addr (dec_waddr),
    .set_en   (issue & dec_wen),
    .chk_addr (dec_waddr),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .pend0    (pend0),
    .pend1    (pend1),
    .chk_pend (dst_pend)
  );

  // ----------------------------------------------------------
  // Hazards and routing
  // ----------------------------------------------------------

  logic                 stall;
  logic                 go;
  issue_pkg::pipe_sel_t pipe_sel;

  // WAW check too, since the pipes differ in latency
  assign stall = pend0 | pend1 | (dec_wen & dst_pend);

  assign pipe_sel = (dec_uop == rv_isa_pkg::uop_mul) ? issue_pkg::pipe_mul
                                                     : issue_pkg::pipe_alu;

  // Valid, decodable and hazard free
  assign go      = fd_val & dec_val & ~stall;
  assign alu_val = go & (pipe_sel == issue_pkg::pipe_alu);
  // Multiplier never back-pressures
  assign mul_val = go & (pipe_sel == issue_pkg::pipe_mul);
  assign issue   = mul_val | (alu_val & alu_rdy);

  // Empty, or emptying this cycle
  assign f_rdy = ~fd_val | issue;

  // Shared operand bus to both pipes
  assign iss_uop     = dec_uop;
  assign iss_op1     = rdata0;
  assign iss_op2     = dec_use_imm ? dec_imm : rdata1;
  assign iss_waddr   = dec_waddr;
  assign iss_seq_num = fd_seq_num;

endmodule

// File: verilog/alu_pipe.sv
/*
  Single-stage ALU pipe for add and addi
  Result is held until the writeback arbiter acknowledges it
*/

`timescale 1ns/1ps

module alu_pipe (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  val,
  output logic                  rdy,
  input  rv_isa_pkg::rv_uop_t   uop,
  input  issue_pkg::word_t      op1,
  input  issue_pkg::word_t      op2,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  issue_pkg::seq_num_t   seq_num,
  input  logic                  ack,
  output logic                  res_val,
  output rv_isa_pkg::reg_addr_t res_waddr,
  output issue_pkg::word_t      res_wdata,
  output issue_pkg::seq_num_t   res_seq
);

  issue_pkg::word_t result;
  logic             accept;

  // Both ops are an add, op2 already muxed with the immediate
  always_comb begin
    case (uop)
      rv_isa_pkg::uop_add,
      rv_isa_pkg::uop_addi: result = op1 + op2;
      default:              result = '0;
    endcase
  end

  // Free slot or slot draining this cycle
  assign rdy    = ~res_val | ack;
  assign accept = val & rdy;

  always_ff @(posedge clk) begin
    if (rst)
      res_val <= 1'b0;
    else if (accept)
      res_val <= 1'b1;
    else if (ack)
      res_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_wdata <= result;
      res_waddr <= waddr;
      res_seq   <= seq_num;
    end
  end

endmodule

// File: verilog/mul_pipe.sv
/*
  Fixed-latency multiplier pipe, low 32 bits of the product
  Depth set by MUL_STAGES, one item per stage in flight
*/

`timescale 1ns/1ps

`include "arith_core_consts.svh"

module mul_pipe (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  val,
  input  issue_pkg::word_t      op1,
  input  issue_pkg::word_t      op2,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  issue_pkg::seq_num_t   seq_num,
  output logic                  res_val,
  output rv_isa_pkg::reg_addr_t res_waddr,
  output issue_pkg::word_t      res_wdata,
  output issue_pkg::seq_num_t   res_seq
);

  logic [`MUL_STAGES-1:0] stg_val;
  issue_pkg::word_t       stg_data  [`MUL_STAGES];
  rv_isa_pkg::reg_addr_t  stg_waddr [`MUL_STAGES];
  issue_pkg::seq_num_t    stg_seq   [`MUL_STAGES];

  // Stage valids, no stall path
  always_ff @(posedge clk) begin
    if (rst) begin
      stg_val <= '0;
    end else begin
      stg_val[0] <= val;
      for (int i = 1; i < `MUL_STAGES; i++)
        stg_val[i] <= stg_val[i-1];
    end
  end

  // Product formed in the first stage, later stages retime it
  always_ff @(posedge clk) begin
    stg_data[0]  <= op1 * op2;
    stg_waddr[0] <= waddr;
    stg_seq[0]   <= seq_num;
    for (int i = 1; i < `MUL_STAGES; i++) begin
      stg_data[i]  <= stg_data[i-1];
      stg_waddr[i] <= stg_waddr[i-1];
      stg_seq[i]   <= stg_seq[i-1];
    end
  end

  // Last stage drives the result group
  assign res_val   = stg_val[`MUL_STAGES-1];
  assign res_wdata = stg_data[`MUL_STAGES-1];
  assign res_waddr = stg_waddr[`MUL_STAGES-1];
  assign res_seq   = stg_seq[`MUL_STAGES-1];

endmodule

// File: verilog/writeback_arb.sv
/*
  Writeback arbiter onto the completion bus
  Multiplier has fixed priority, ALU waits and is acked
*/

`timescale 1ns/1ps

module writeback_arb (
  input  logic                  alu_res_val,
  input  rv_isa_pkg::reg_addr_t alu_res_waddr,
  input  issue_pkg::word_t      alu_res_wdata,
  input  issue_pkg::seq_num_t   alu_res_seq,
  input  logic                  mul_res_val,
  input  rv_isa_pkg::reg_addr_t mul_res_waddr,
  input  issue_pkg::word_t      mul_res_wdata,
  input  issue_pkg::seq_num_t   mul_res_seq,
  output logic                  alu_ack,
  output logic                  cmt_val,
  output rv_isa_pkg::reg_addr_t cmt_waddr,
  output issue_pkg::word_t      cmt_wdata,
  output issue_pkg::seq_num_t   cmt_seq_num
);

  // Multiplier cannot stall, so it always wins
  always_comb begin
    if (mul_res_val) begin
      cmt_val     = 1'b1;
      cmt_waddr   = mul_res_waddr;
      cmt_wdata   = mul_res_wdata;
      cmt_seq_num = mul_res_seq;
    end else begin
      cmt_val     = alu_res_val;
      cmt_waddr   = alu_res_waddr;
      cmt_wdata   = alu_res_wdata;
      cmt_seq_num = alu_res_seq;
    end
  end

  // Ack only when the ALU result actually goes out
  assign alu_ack = alu_res_val & ~mul_res_val;

endmodule

// File: verilog/arith_core.sv
/*
  Arithmetic core top level
  Decode/issue, ALU and multiplier pipes, writeback arbiter
*/

`timescale 1ns/1ps

module arith_core (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  f_val,
  output logic                  f_rdy,
  input  rv_isa_pkg::inst_t     f_inst,
  input  issue_pkg::word_t      f_pc,
  input  issue_pkg::seq_num_t   f_seq_num,
  output logic                  cmt_val,
  output rv_isa_pkg::reg_addr_t cmt_waddr,
  output issue_pkg::word_t      cmt_wdata,
  output issue_pkg::seq_num_t   cmt_seq_num
);

  // Issue bus, shared by both pipes
  logic                  alu_val;
  logic                  alu_rdy;
  logic                  mul_val;
  rv_isa_pkg::rv_uop_t   iss_uop;
  issue_pkg::word_t      iss_op1;
  issue_pkg::word_t      iss_op2;
  rv_isa_pkg::reg_addr_t iss_waddr;
  issue_pkg::seq_num_t   iss_seq_num;

  // Pipe result groups
  logic                  alu_ack;
  logic                  alu_res_val;
  rv_isa_pkg::reg_addr_t alu_res_waddr;
  issue_pkg::word_t      alu_res_wdata;
  issue_pkg::seq_num_t   alu_res_seq;
  logic                  mul_res_val;
  rv_isa_pkg::reg_addr_t mul_res_waddr;
  issue_pkg::word_t      mul_res_wdata;
  issue_pkg::seq_num_t   mul_res_seq;

  decode_issue_unit diu (
    .clk (clk), .rst (rst),
    .f_val (f_val), .f_rdy (f_rdy), .f_inst (f_inst), .f_pc (f_pc),
    .f_seq_num (f_seq_num),
    .alu_val (alu_val), .alu_rdy (alu_rdy), .mul_val (mul_val),
    .iss_uop (iss_uop), .iss_op1 (iss_op1), .iss_op2 (iss_op2),
    .iss_waddr (iss_waddr), .iss_seq_num (iss_seq_num),
    .cmt_val (cmt_val), .cmt_waddr (cmt_waddr), .cmt_wdata (cmt_wdata)
  );

  alu_pipe alu (
    .clk (clk), .rst (rst),
    .val (alu_val), .rdy (alu_rdy), .uop (iss_uop),
    .op1 (iss_op1), .op2 (iss_op2), .waddr (iss_waddr), .seq_num (iss_seq_num),
    .ack (alu_ack),
    .res_val (alu_res_val), .res_waddr (alu_res_waddr),
    .res_wdata (alu_res_wdata), .res_seq (alu_res_seq)
  );

  mul_pipe mul (
    .clk (clk), .rst (rst),
    .val (mul_val), .op1 (iss_op1), .op2 (iss_op2),
    .waddr (iss_waddr), .seq_num (iss_seq_num),
    .res_val (mul_res_val), .res_waddr (mul_res_waddr),
    .res_wdata (mul_res_wdata), .res_seq (mul_res_seq)
  );

  // Completion bus also feeds the register file inside diu
  writeback_arb arb (
    .alu_res_val (alu_res_val), .alu_res_waddr (alu_res_waddr),
    .alu_res_wdata (alu_res_wdata), .alu_res_seq (alu_res_seq),
    .mul_res_val (mul_res_val), .mul_res_waddr (mul_res_waddr),
    .mul_res_wdata (mul_res_wdata), .mul_res_seq (mul_res_seq),
    .alu_ack (alu_ack),
    .cmt_val (cmt_val), .cmt_waddr (cmt_waddr),
    .cmt_wdata (cmt_wdata), .cmt_seq_num (cmt_seq_num)
  );

endmodule

// File: verif/commit_checker.sv
/*
  Completion bus checker for the arithmetic core testbench
  Holds expected destination and data per sequence number
  Counts completions and mismatches
*/

`timescale 1ns/1ps

`include "arith_core_consts.svh"

module commit_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  cmt_val,
  input rv_isa_pkg::reg_addr_t cmt_waddr,
  input issue_pkg::word_t      cmt_wdata,
  input issue_pkg::seq_num_t   cmt_seq_num
);

  localparam int NUM_TAGS = 1 << `SEQ_NUM_BITS;

  // ------------------------------------------------------------
  // Expectation table, filled by the stimulus side
  // ------------------------------------------------------------

  string                 test_name = "none";
  rv_isa_pkg::reg_addr_t exp_waddr  [NUM_TAGS];
  issue_pkg::word_t      exp_wdata  [NUM_TAGS];
  // Uses of a tag, sent vs completed; they differ while in flight
  int                    issued_cnt [NUM_TAGS];
  int                    done_cnt   [NUM_TAGS];
  int                    sent_total = 0;
  int                    done_total = 0;
  int                    errors     = 0;

  task automatic begin_test(input string name);
    test_name = name;
  endtask

  task automatic expect_commit(input issue_pkg::seq_num_t seq,
                               input rv_isa_pkg::reg_addr_t waddr,
                               input issue_pkg::word_t wdata);
    exp_waddr[seq] = waddr;
    exp_wdata[seq] = wdata;
    issued_cnt[seq]++;
    sent_total++;
  endtask

  // Sent but not yet completed
  function automatic int outstanding();
    return sent_total - done_total;
  endfunction

  initial begin
    for (int i = 0; i < NUM_TAGS; i++) begin
      issued_cnt[i] = 0;
      done_cnt[i]   = 0;
    end
  end

  // ------------------------------------------------------------
  // Compare, mid-cycle where the combinational bus is settled
  // ------------------------------------------------------------

  always @(negedge clk) begin
    if (!rst) begin
      if ($isunknown(cmt_val)) begin
        $display("Completion valid is unknown in test %s", test_name);
        errors++;
      end else if (cmt_val) begin
        // Tag never sent, or completed twice
        if (done_cnt[cmt_seq_num] >= issued_cnt[cmt_seq_num]) begin
          $display("Completion for seq %0d in test %s was never sent or came twice",
                   cmt_seq_num, test_name);
          errors++;
        end else begin
          if (cmt_waddr !== exp_waddr[cmt_seq_num]) begin
            $display("ERR %s seq %0d waddr expected %0d actual %0d", test_name,
                     cmt_seq_num, exp_waddr[cmt_seq_num], cmt_waddr);
            errors++;
          end
          if (cmt_wdata !== exp_wdata[cmt_seq_num]) begin
            $display("ERR %s seq %0d wdata expected %08h actual %08h", test_name,
                     cmt_seq_num, exp_wdata[cmt_seq_num], cmt_wdata);
            errors++;
          end
          done_cnt[cmt_seq_num]++;
          done_total++;
        end
      end
    end
  end

endmodule

// File: verif/arith_core_tb.sv
/*
  Testbench for the arithmetic core
  Clock, reset, xorshift stimulus, sequential register model
  Directed and random tests, summary and final verdict
*/

`timescale 1ns/1ps

module arith_core_tb;

  logic                  clk;
  logic                  rst;
  logic                  f_val;
  logic                  f_rdy;
  rv_isa_pkg::inst_t     f_inst;
  issue_pkg::word_t      f_pc;
  issue_pkg::seq_num_t   f_seq_num;
  logic                  cmt_val;
  rv_isa_pkg::reg_addr_t cmt_waddr;
  issue_pkg::word_t      cmt_wdata;
  issue_pkg::seq_num_t   cmt_seq_num;

  arith_core arith_core_i (
    .clk         (clk),
    .rst         (rst),
    .f_val       (f_val),
    .f_rdy       (f_rdy),
    .f_inst      (f_inst),
    .f_pc        (f_pc),
    .f_seq_num   (f_seq_num),
    .cmt_val     (cmt_val),
    .cmt_waddr   (cmt_waddr),
    .cmt_wdata   (cmt_wdata),
    .cmt_seq_num (cmt_seq_num)
  );

  commit_checker commit_checker_i (
    .clk         (clk),
    .rst         (rst),
    .cmt_val     (cmt_val),
    .cmt_waddr   (cmt_waddr),
    .cmt_wdata   (cmt_wdata),
    .cmt_seq_num (cmt_seq_num)
  );

  // 10 ns period
  always #5 clk = ~clk;

  // ------------------------------------------------------------
  // Random source and instruction encoding
  // ------------------------------------------------------------

  logic [31:0]         rng_state = 32'h826d;
  logic [31:0]         model_regs [32];
  issue_pkg::seq_num_t seq = '0;
  issue_pkg::word_t    pc = '0;
  bit                  use_gaps = 1'b0;
  bit                  timed_out = 1'b0;
  string               cur_test;
  int                  errs_at_start;
  int                  tests_run = 0;
  int                  tests_failed = 0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // RV32 R-type and I-type layouts
  function automatic logic [31:0] encode_inst(input rv_isa_pkg::rv_uop_t op,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [11:0] imm);
    case (op)
      rv_isa_pkg::uop_addi: return {imm, rs1, 3'b000, rd, 7'b0010011};
      rv_isa_pkg::uop_mul:  return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
      default:              return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endcase
  endfunction

  // Architectural result, low 32 bits
  function automatic logic [31:0] model_result(input rv_isa_pkg::rv_uop_t op,
                                               input logic [31:0] a, input logic [31:0] b,
                                               input logic [11:0] imm);
    case (op)
      rv_isa_pkg::uop_addi: return a + {{20{imm[11]}}, imm};
      rv_isa_pkg::uop_mul:  return a * b;
      default:              return a + b;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Stimulus tasks, all leave time just after a rising edge
  // ------------------------------------------------------------

  task automatic send(input rv_isa_pkg::rv_uop_t op, input int rd, input int rs1,
                      input int rs2, input int imm);
    logic [31:0] r;
    logic [31:0] res;
    int          waited;
    if (timed_out)
      return;
    // Optional idle gap before the request
    if (use_gaps) begin
      r = next_rand();
      if (r[1:0] == 2'b00) begin
        repeat (1 + int'(r[3:2])) @(posedge clk);
        #1;
      end
    end
    f_val     = 1'b1;
    f_inst    = encode_inst(op, 5'(rd), 5'(rs1), 5'(rs2), 12'(imm));
    f_pc      = pc;
    f_seq_num = seq;
    waited = 0;
    @(negedge clk);
    while (!f_rdy && waited < 200) begin
      waited++;
      @(negedge clk);
    end
    if (!f_rdy) begin
      $display("Timeout: fetch not ready for 200 cycles at seq %0d in %s", seq, cur_test);
      timed_out = 1'b1;
      f_val = 1'b0;
      return;
    end
    // Transfer on this edge
    @(posedge clk);
    #1;
    res = model_result(op, model_regs[rs1], model_regs[rs2], 12'(imm));
    commit_checker_i.expect_commit(seq, 5'(rd), res);
    // x0 writes dropped
    if (rd != 0)
      model_regs[rd] = res;
    seq++;
    pc += 32'd4;
    f_val = 1'b0;
  endtask

  // Registers limited to x0..x7 for frequent hazards
  task automatic send_random(input int mul_pct);
    logic [31:0]         r;
    rv_isa_pkg::rv_uop_t op;
    r = next_rand();
    if ((r % 100) < mul_pct)
      op = rv_isa_pkg::uop_mul;
    else if (r[8])
      op = rv_isa_pkg::uop_addi;
    else
      op = rv_isa_pkg::uop_add;
    send(op, int'(r[12:10]), int'(r[15:13]), int'(r[18:16]), int'(r[30:19]));
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  // Wait for every sent instruction to complete
  task automatic drain();
    int waited;
    waited = 0;
    while (commit_checker_i.outstanding() != 0 && waited < 200) begin
      @(posedge clk);
      waited++;
    end
    if (commit_checker_i.outstanding() != 0) begin
      $display("Timeout: %0d instructions never completed in %s",
               commit_checker_i.outstanding(), cur_test);
      timed_out = 1'b1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errs_at_start = commit_checker_i.errors;
    commit_checker_i.begin_test(name);
  endtask

  task automatic end_test();
    int errs;
    drain();
    errs = commit_checker_i.errors - errs_at_start;
    tests_run++;
    if (errs != 0 || timed_out)
      tests_failed++;
    $display("Test %-12s %s, %0d errors", cur_test,
             (errs == 0 && !timed_out) ? "ok" : "FAILED", errs);
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    f_val     = 1'b0;
    f_inst    = '0;
    f_pc      = '0;
    f_seq_num = '0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Bus must stay quiet with nothing sent
    start_test("reset_idle");
    idle(8);
    end_test();

    // Immediate sign extension at both 12-bit limits
    start_test("add_addi");
    send(rv_isa_pkg::uop_addi, 1, 0, 0, 100);
    send(rv_isa_pkg::uop_addi, 2, 0, 0, -7);
    send(rv_isa_pkg::uop_add, 3, 1, 2, 0);
    send(rv_isa_pkg::uop_addi, 4, 3, 0, 2047);
    send(rv_isa_pkg::uop_addi, 5, 4, 0, -2048);
    send(rv_isa_pkg::uop_add, 6, 5, 5, 0);
    for (int i = 0; i < 20; i++)
      send_random(0);
    end_test();

    // Negative operands and wrap past 32 bits
    start_test("mul");
    send(rv_isa_pkg::uop_addi, 1, 0, 0, -3);
    send(rv_isa_pkg::uop_addi, 2, 0, 0, 7);
    send(rv_isa_pkg::uop_mul, 3, 1, 2, 0);
    send(rv_isa_pkg::uop_mul, 4, 3, 3, 0);
    send(rv_isa_pkg::uop_addi, 5, 0, 0, -1);
    send(rv_isa_pkg::uop_mul, 6, 5, 1, 0);
    send(rv_isa_pkg::uop_addi, 7, 0, 0, 2047);
    send(rv_isa_pkg::uop_mul, 7, 7, 7, 0);
    send(rv_isa_pkg::uop_mul, 7, 7, 7, 0);
    end_test();

    // RAW and WAW around the multiplier, ALU overtaking
    start_test("dep_chain");
    send(rv_isa_pkg::uop_addi, 1, 0, 0, 5);
    send(rv_isa_pkg::uop_mul, 2, 1, 1, 0);
    send(rv_isa_pkg::uop_addi, 5, 0, 0, 9);
    send(rv_isa_pkg::uop_add, 3, 2, 1, 0);
    send(rv_isa_pkg::uop_mul, 4, 3, 5, 0);
    send(rv_isa_pkg::uop_addi, 6, 0, 0, -4);
    send(rv_isa_pkg::uop_addi, 2, 6, 0, 3);
    send(rv_isa_pkg::uop_mul, 2, 2, 4, 0);
    send(rv_isa_pkg::uop_addi, 2, 2, 0, 1);
    send(rv_isa_pkg::uop_add, 7, 2, 2, 0);
    end_test();

    // x0 as destination and source
    start_test("x0");
    send(rv_isa_pkg::uop_addi, 0, 0, 0, 55);
    send(rv_isa_pkg::uop_add, 0, 1, 2, 0);
    send(rv_isa_pkg::uop_mul, 0, 1, 1, 0);
    send(rv_isa_pkg::uop_add, 3, 0, 0, 0);
    send(rv_isa_pkg::uop_addi, 4, 0, 0, -9);
    send(rv_isa_pkg::uop_mul, 5, 0, 4, 0);
    end_test();

    // Mixed traffic with fetch gaps
    start_test("random");
    use_gaps = 1'b1;
    for (int i = 0; i < 150; i++)
      send_random(35);
    end_test();

    // Back-to-back, mostly multiplies
    start_test("mul_burst");
    use_gaps = 1'b0;
    for (int i = 0; i < 40; i++)
      send_random(70);
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d completions, %0d errors",
             tests_run, tests_failed, commit_checker_i.done_total, commit_checker_i.errors);
    if (tests_failed == 0 && !timed_out && commit_checker_i.errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: arith_core.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/issue_pkg.sv
verilog/inst_decoder.sv
verilog/regfile_pending.sv
verilog/decode_issue_unit.sv
verilog/alu_pipe.sv
verilog/mul_pipe.sv
verilog/writeback_arb.sv
verilog/arith_core.sv
verif/commit_checker.sv
verif/arith_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := arith_core_tb
FILELIST := arith_core.f
OBJDIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJDIR)
